// File: verilog/fetchPkg.sv
// Shared opcode, control and decoded-instruction types for the 16-bit fetch stage; SIIC/RTI decode as no-ops
package fetchPkg;

    // Five-bit major opcodes, instr[15:11]
    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opSiic  = 5'b00010,
        opRti   = 5'b00011,
        opJ     = 5'b00100,
        opJr    = 5'b00101,
        opJal   = 5'b00110,
        opJalr  = 5'b00111,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opBltz  = 5'b01110,
        opBgez  = 5'b01111,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opSlbi  = 5'b10010,
        opStu   = 5'b10011,
        opRoli  = 5'b10100,
        opSlli  = 5'b10101,
        opRori  = 5'b10110,
        opSrli  = 5'b10111,
        opLbi   = 5'b11000,
        opBtr   = 5'b11001,
        opAdd   = 5'b11011,  // ADD/SUB/XOR/ANDN picked by instr[1:0]
        opSeq   = 5'b11100,
        opSlt   = 5'b11101,
        opSle   = 5'b11110,
        opSco   = 5'b11111
    } opcodeT;

    // Where the write register number comes from
    typedef enum logic [1:0] {
        destRs  = 2'b00,  // instr[10:8]
        destRdR = 2'b01,  // instr[4:2]
        destR7  = 2'b10,
        destRdI = 2'b11   // instr[7:5]
    } destSelT;

    // Immediate formats for immSel
    localparam logic [2:0] immZext5  = 3'd0;
    localparam logic [2:0] immSext5  = 3'd1;
    localparam logic [2:0] immZext8  = 3'd2;
    localparam logic [2:0] immSext8  = 3'd3;
    localparam logic [2:0] immSext11 = 3'd4;

    // Writeback source when not from memory
    localparam logic [1:0] wbAlu  = 2'd0;
    localparam logic [1:0] wbLink = 2'd1;  // PC + 2
    localparam logic [1:0] wbImm  = 2'd2;

    typedef struct packed {
        logic       regWrite;
        destSelT    destSel;
        logic       memEnable;
        logic       memWr;
        logic       val2Reg;   // Memory data to register
        logic       aluSel;    // Immediate as second ALU operand
        logic [2:0] immSel;
        logic [1:0] linkReg;
        logic       regJmp;
        logic       bFlag;
        logic       jFlag;
        logic       halt;
        logic       ctrlErr;
        logic       readsRs;
        logic       readsRt;
    } controlT;

    typedef struct packed {
        logic [15:0] instr;
        logic [15:0] pc;
        logic [15:0] pcInc;
        controlT     control;
        logic [2:0]  writeRegAddr;
    } decodedT;

    localparam logic [15:0] nopInstr = 16'h0800;
    localparam logic [2:0]  regR7    = 3'd7;

    // All enables low and destination field rs
    localparam controlT nopControl = controlT'(19'd0);

endpackage

// File: verilog/programCounter.sv
// PC steps by 2 per word; once HALT is decoded the PC stays put until reset, redirects included
module programCounter #(
    parameter logic [15:0] resetPc = 16'h0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        hold,
    input  logic        halt,
    input  logic        redirect,
    input  logic [15:0] redirectTarget,
    input  logic        regJmp,
    input  logic [15:0] jumpBase,
    input  logic [15:0] jumpOffset,
    output logic [15:0] pc,
    output logic [15:0] pcInc
);

    logic        halted;
    logic [15:0] nextPc;

    assign pcInc = pc + 16'd2;

    // Hold and halt freeze the PC, then redirect, register jump and sequential
    always_comb begin
        if (hold || halted || halt) begin
            nextPc = pc;
        end else if (redirect) begin
            nextPc = redirectTarget;
        end else if (regJmp) begin
            nextPc = jumpBase + jumpOffset;  // JR/JALR target
        end else begin
            nextPc = pcInc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= resetPc;
            halted <= 1'b0;
        end else begin
            pc <= nextPc;
            if (halt && !hold) begin
                halted <= 1'b1;  // Sticky until reset
            end
        end
    end

endmodule

// File: verilog/instrMemory.sv
// Word store with asynchronous read, written only during reset; depth at most 32768, unloaded words read X
module instrMemory #(
    parameter int unsigned imemDepth = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        loadEn,
    input  logic [15:0] loadAddr,
    input  logic [15:0] loadData,
    input  logic [15:0] addr,
    output logic [15:0] instr
);

    localparam int unsigned indexBits = (imemDepth > 1) ? $clog2(imemDepth) : 1;

    logic [15:0] mem [imemDepth];
    logic [14:0] readWord;
    logic [14:0] loadWord;

    // Byte address to word index
    assign readWord = addr[15:1];
    assign loadWord = loadAddr[15:1];

    always_ff @(posedge clk) begin
        if (reset && loadEn && (loadWord < imemDepth)) begin
            mem[loadWord[indexBits-1:0]] <= loadData;
        end
    end

    // Out of range fetches become NOPs
    always_comb begin
        if (readWord < imemDepth) begin
            instr = mem[readWord[indexBits-1:0]];
        end else begin
            instr = fetchPkg::nopInstr;
        end
    end

endmodule

// File: verilog/controlDecode.sv
// Combinational decode of instr[15:11]; opcode 11010 and other unlisted codes raise ctrlErr only
module controlDecode (
    input  logic [15:0]       instr,
    output fetchPkg::controlT control,
    output logic [2:0]        writeRegAddr
);

    fetchPkg::opcodeT opcode;

    assign opcode = fetchPkg::opcodeT'(instr[15:11]);

    always_comb begin
        control = fetchPkg::nopControl;
        case (opcode)
            fetchPkg::opHalt: control.halt = 1'b1;
            fetchPkg::opNop, fetchPkg::opSiic, fetchPkg::opRti: begin
                control = fetchPkg::nopControl;  // No handler here
            end
            fetchPkg::opAddi, fetchPkg::opSubi: begin
                control.regWrite = 1'b1;
                control.destSel  = fetchPkg::destRdI;
                control.aluSel   = 1'b1;
                control.immSel   = fetchPkg::immSext5;
                control.readsRs  = 1'b1;
            end
            fetchPkg::opXori, fetchPkg::opAndni, fetchPkg::opRoli, fetchPkg::opSlli,
            fetchPkg::opRori, fetchPkg::opSrli: begin
                control.regWrite = 1'b1;
                control.destSel  = fetchPkg::destRdI;
                control.aluSel   = 1'b1;
                control.immSel   = fetchPkg::immZext5;
                control.readsRs  = 1'b1;
            end
            fetchPkg::opSt, fetchPkg::opStu: begin
                control.memEnable = 1'b1;
                control.memWr     = 1'b1;
                control.aluSel    = 1'b1;
                control.immSel    = fetchPkg::immSext5;
                control.readsRs   = 1'b1;
                control.readsRt   = 1'b1;  // Store data in instr[7:5]
                control.regWrite  = (opcode == fetchPkg::opStu);  // STU updates base
                control.destSel   = fetchPkg::destRs;
            end
            fetchPkg::opLd: begin
                control.regWrite  = 1'b1;
                control.destSel   = fetchPkg::destRdI;
                control.memEnable = 1'b1;
                control.val2Reg   = 1'b1;
                control.aluSel    = 1'b1;
                control.immSel    = fetchPkg::immSext5;
                control.readsRs   = 1'b1;
            end
            fetchPkg::opBtr: begin
                control.regWrite = 1'b1;
                control.destSel  = fetchPkg::destRdR;
                control.readsRs  = 1'b1;
            end
            fetchPkg::opAdd, fetchPkg::opSeq, fetchPkg::opSlt, fetchPkg::opSle,
            fetchPkg::opSco: begin
                control.regWrite = 1'b1;
                control.destSel  = fetchPkg::destRdR;
                control.readsRs  = 1'b1;
                control.readsRt  = 1'b1;
            end
            fetchPkg::opBeqz, fetchPkg::opBnez, fetchPkg::opBltz, fetchPkg::opBgez: begin
                control.bFlag   = 1'b1;
                control.immSel  = fetchPkg::immSext8;
                control.readsRs = 1'b1;
            end
            fetchPkg::opLbi: begin
                control.regWrite = 1'b1;
                control.destSel  = fetchPkg::destRs;
                control.immSel   = fetchPkg::immSext8;
                control.linkReg  = fetchPkg::wbImm;
            end
            fetchPkg::opSlbi: begin
                control.regWrite = 1'b1;
                control.destSel  = fetchPkg::destRs;
                control.aluSel   = 1'b1;
                control.immSel   = fetchPkg::immZext8;
                control.readsRs  = 1'b1;
            end
            fetchPkg::opJ, fetchPkg::opJal: begin
                control.jFlag    = 1'b1;
                control.immSel   = fetchPkg::immSext11;
                control.regWrite = (opcode == fetchPkg::opJal);
                control.destSel  = fetchPkg::destR7;
                control.linkReg  = (opcode == fetchPkg::opJal) ? fetchPkg::wbLink
                                                                : fetchPkg::wbAlu;
            end
            fetchPkg::opJr, fetchPkg::opJalr: begin
                control.regJmp   = 1'b1;
                control.immSel   = fetchPkg::immSext8;
                control.readsRs  = 1'b1;
                control.regWrite = (opcode == fetchPkg::opJalr);
                control.destSel  = fetchPkg::destR7;
                control.linkReg  = (opcode == fetchPkg::opJalr) ? fetchPkg::wbLink
                                                                 : fetchPkg::wbAlu;
            end
            default: control.ctrlErr = 1'b1;  // Enables stay low
        endcase
    end

    always_comb begin
        case (control.destSel)
            fetchPkg::destRs:  writeRegAddr = instr[10:8];
            fetchPkg::destRdR: writeRegAddr = instr[4:2];
            fetchPkg::destR7:  writeRegAddr = fetchPkg::regR7;
            default:           writeRegAddr = instr[7:5];
        endcase
    end

endmodule

// File: verilog/hazardDetect.sv
// Load-use check against the last issued LD only; one bubble per hazard, history frozen while stalled
module hazardDetect (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic [15:0] instr,
    output logic        insertNop
);

    fetchPkg::opcodeT opcode;
    logic             loadPending;
    logic [2:0]       loadDest;
    logic             readsRs;
    logic             readsRt;

    assign opcode = fetchPkg::opcodeT'(instr[15:11]);

    // Which source fields the raw word reads
    always_comb begin
        readsRs = 1'b0;
        readsRt = 1'b0;
        case (opcode)
            fetchPkg::opSt, fetchPkg::opStu, fetchPkg::opAdd, fetchPkg::opSeq,
            fetchPkg::opSlt, fetchPkg::opSle, fetchPkg::opSco: begin
                readsRs = 1'b1;
                readsRt = 1'b1;
            end
            fetchPkg::opAddi, fetchPkg::opSubi, fetchPkg::opXori, fetchPkg::opAndni,
            fetchPkg::opRoli, fetchPkg::opSlli, fetchPkg::opRori, fetchPkg::opSrli,
            fetchPkg::opLd, fetchPkg::opSlbi, fetchPkg::opBtr, fetchPkg::opBeqz,
            fetchPkg::opBnez, fetchPkg::opBltz, fetchPkg::opBgez, fetchPkg::opJr,
            fetchPkg::opJalr: begin
                readsRs = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign insertNop = loadPending &&
                       ((readsRs && (instr[10:8] == loadDest)) ||
                        (readsRt && (instr[7:5] == loadDest)));

    // Bubble cycle clears the history
    always_ff @(posedge clk) begin
        if (reset) begin
            loadPending <= 1'b0;
        end else if (!stall) begin
            loadPending <= !insertNop && (opcode == fetchPkg::opLd);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !insertNop) begin
            loadDest <= instr[7:5];  // LD target field
        end
    end

endmodule

// File: verilog/decodeRegister.sv
// Output register of the stage; NOP control after reset, full hold while stall is high
module decodeRegister (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  fetchPkg::decodedT next,
    output fetchPkg::decodedT decoded,
    output logic              decodedValid
);

    fetchPkg::controlT ctrlReg;
    logic [15:0]       instrReg;
    logic [15:0]       pcReg;
    logic [15:0]       pcIncReg;
    logic [2:0]        destReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlReg      <= fetchPkg::nopControl;
            instrReg     <= fetchPkg::nopInstr;
            decodedValid <= 1'b0;
        end else if (!stall) begin
            ctrlReg      <= next.control;
            instrReg     <= next.instr;
            decodedValid <= 1'b1;  // Bubbles count as valid
        end
    end

    // Payload fields
    always_ff @(posedge clk) begin
        if (!stall) begin
            pcReg    <= next.pc;
            pcIncReg <= next.pcInc;
            destReg  <= next.writeRegAddr;
        end
    end

    assign decoded = '{
        instr:        instrReg,
        pc:           pcReg,
        pcInc:        pcIncReg,
        control:      ctrlReg,
        writeRegAddr: destReg
    };

endmodule

// File: verilog/fetchDecode.sv
// Fetch and decode top; program loads only under reset, redirect and JR/JALR targets take effect next edge
module fetchDecode #(
    parameter int unsigned imemDepth = 256,
    parameter logic [15:0] resetPc   = 16'h0000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              loadEn,
    input  logic [15:0]       loadAddr,
    input  logic [15:0]       loadData,
    input  logic              redirect,
    input  logic [15:0]       redirectTarget,
    input  logic [15:0]       rsData,
    input  logic [15:0]       immData,
    input  logic              stall,
    output fetchPkg::decodedT decoded,
    output logic              decodedValid
);

    logic [15:0]       pc;
    logic [15:0]       pcInc;
    logic [15:0]       rawInstr;
    logic [15:0]       issueInstr;
    logic              insertNop;
    fetchPkg::controlT control;
    logic [2:0]        writeRegAddr;
    fetchPkg::decodedT nextDecoded;

    programCounter #(.resetPc(resetPc)) pcUnit (
        .clk           (clk),
        .reset         (reset),
        .hold          (stall || insertNop),  // Hazard bubble also freezes PC
        .halt          (control.halt),
        .redirect      (redirect),
        .redirectTarget(redirectTarget),
        .regJmp        (control.regJmp),
        .jumpBase      (rsData),
        .jumpOffset    (immData),
        .pc            (pc),
        .pcInc         (pcInc)
    );

    instrMemory #(.imemDepth(imemDepth)) imem (
        .clk     (clk),
        .reset   (reset),
        .loadEn  (loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .addr    (pc),
        .instr   (rawInstr)
    );

    hazardDetect hazard (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .instr    (rawInstr),
        .insertNop(insertNop)
    );

    assign issueInstr = insertNop ? fetchPkg::nopInstr : rawInstr;

    controlDecode decoder (
        .instr       (issueInstr),
        .control     (control),
        .writeRegAddr(writeRegAddr)
    );

    assign nextDecoded = '{
        instr:        issueInstr,
        pc:           pc,
        pcInc:        pcInc,
        control:      control,
        writeRegAddr: writeRegAddr
    };

    decodeRegister outReg (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .next        (nextDecoded),
        .decoded     (decoded),
        .decodedValid(decodedValid)
    );

endmodule

// File: verif/fetchDecode_properties.sv
// Bound into fetchDecode and reads its internal pc and insertNop; stall and bubble checks start after reset
module fetchDecode_properties (
    input logic              clk,
    input logic              reset,
    input logic              stall,
    input logic              insertNop,
    input logic [15:0]       pc,
    input fetchPkg::decodedT decoded,
    input logic              decodedValid
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;

    property holdUnderStall;
        @(posedge clk) disable iff (reset)
            stall |=> ($stable(decoded) && $stable(pc));
    endproperty

    // One bubble per load-use hazard
    property singleBubble;
        @(posedge clk) disable iff (reset)
            (insertNop && !stall) |=> !insertNop;
    endproperty

    // From the second reset cycle on the register holds its reset value
    property quietInReset;
        @(posedge clk)
            (reset ##1 reset) |->
                (!decoded.control.regWrite && !decoded.control.memEnable && !decodedValid);
    endproperty

    assertStallHold: assert property (holdUnderStall)
        else begin
            failCount = failCount + 1;
            $error("decoded or pc changed while stall was high");
        end

    assertSingleBubble: assert property (singleBubble)
        else begin
            failCount = failCount + 1;
            $error("insertNop high for two unstalled cycles in a row");
        end

    assertResetQuiet: assert property (quietInReset)
        else begin
            failCount = failCount + 1;
            $error("write, memory or valid output active during reset");
        end

endmodule

bind fetchDecode fetchDecode_properties props (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .insertNop   (insertNop),
    .pc          (pc),
    .decoded     (decoded),
    .decodedValid(decodedValid)
);

// File: verif/fetchDecodeTb.sv
// Run from the project root so verif/fetchTrace.txt is found; the program loads while reset is high
module fetchDecodeTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int traceWords  = 1024;
    localparam int recordWords = 13;
    localparam int resetCycles = 5;
    localparam int waitLimit   = 20;

    logic              clk;
    logic              reset;
    logic              loadEn;
    logic [15:0]       loadAddr;
    logic [15:0]       loadData;
    logic              redirect;
    logic [15:0]       redirectTarget;
    logic [15:0]       rsData;
    logic [15:0]       immData;
    logic              stall;
    fetchPkg::decodedT decoded;
    logic              decodedValid;

    logic [15:0] traceMem [traceWords];
    int          tracePtr;
    int          cycleCount;

    // Compared fields in the order of the expected columns
    string fieldNames [8] = '{"decoded.pc", "decoded.instr", "regWrite", "writeRegAddr",
                              "memEnable", "ctrlErr", "halt", "decodedValid"};

    fetchDecode #(.imemDepth(256), .resetPc(16'h0000)) UUT (
        .clk           (clk),
        .reset         (reset),
        .loadEn        (loadEn),
        .loadAddr      (loadAddr),
        .loadData      (loadData),
        .redirect      (redirect),
        .redirectTarget(redirectTarget),
        .rsData        (rsData),
        .immData       (immData),
        .stall         (stall),
        .decoded       (decoded),
        .decodedValid  (decodedValid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic checkValue(input string signalName, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0d ns: %s expected %h, got %h",
                     $time, signalName, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic reportFailure(input string reason);
        $display("ERROR at time %0d ns: %s", $time, reason);
        $display("Simulation FAILED");
        $fatal(1, "Stopped on error");
    endtask

    // One word per falling edge with word i at byte address 2*i
    task automatic loadProgram();
        int programWords;
        programWords = traceMem[0];
        for (int i = 0; i < programWords; i++) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = 16'(2 * i);
            loadData = traceMem[1 + i];
        end
        @(negedge clk);
        loadEn   = 1'b0;
        tracePtr = 1 + programWords;
    endtask

    task automatic waitForValid();
        int cycles;
        cycles = 0;
        while (decodedValid !== 1'b1) begin
            if (cycles == waitLimit) begin
                reportFailure("decodedValid never rose after reset was released");
            end
            @(posedge clk);
            #5;
            cycles++;
        end
    endtask

    task automatic waitForHalt();
        int cycles;
        cycles = 0;
        while (decoded.control.halt !== 1'b1) begin
            if (cycles == waitLimit) begin
                reportFailure("the halt control never reached the output");
            end
            @(posedge clk);
            #5;
            cycles++;
        end
    endtask

    task automatic runRecord();
        logic [15:0] rec [recordWords];
        logic [15:0] actual [8];
        for (int i = 0; i < recordWords; i++) begin
            rec[i] = traceMem[tracePtr + i];
        end
        @(negedge clk);
        redirect       = rec[0][0];
        redirectTarget = rec[1];
        rsData         = rec[2];
        immData        = rec[3];
        stall          = rec[4][0];
        @(posedge clk);
        #5;  // Well clear of the edge
        actual[0] = decoded.pc;
        actual[1] = decoded.instr;
        actual[2] = {15'd0, decoded.control.regWrite};
        actual[3] = {13'd0, decoded.writeRegAddr};
        actual[4] = {15'd0, decoded.control.memEnable};
        actual[5] = {15'd0, decoded.control.ctrlErr};
        actual[6] = {15'd0, decoded.control.halt};
        actual[7] = {15'd0, decodedValid};
        for (int i = 0; i < 8; i++) begin
            checkValue(fieldNames[i], rec[5 + i], actual[i]);
        end
        // Link value is the next word address
        checkValue("decoded.pcInc", rec[5] + 16'd2, decoded.pcInc);
        tracePtr += recordWords;
    endtask

    initial begin
        reset          = 1'b1;
        loadEn         = 1'b0;
        loadAddr       = 16'h0000;
        loadData       = 16'h0000;
        redirect       = 1'b0;
        redirectTarget = 16'h0000;
        rsData         = 16'h0000;
        immData        = 16'h0000;
        stall          = 1'b0;
        tracePtr       = 0;
        $readmemh("verif/fetchTrace.txt", traceMem);
        if ($isunknown(traceMem[0])) begin
            reportFailure("verif/fetchTrace.txt could not be read");
        end
        loadProgram();
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        waitForValid();  // Word 0 is a NOP so the trace starts at address 2
        cycleCount = traceMem[tracePtr];
        tracePtr++;
        for (int n = 0; n < cycleCount; n++) begin
            runRecord();
        end
        waitForHalt();
        if (UUT.props.failCount == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d bound assertion failures", UUT.props.failCount);
            $display("Simulation FAILED");
            $fatal(1, "Stopped on assertion failures");
        end
    end

endmodule

// File: fetchDecode.f
verilog/fetchPkg.sv
verilog/programCounter.sv
verilog/instrMemory.sv
verilog/controlDecode.sv
verilog/hazardDetect.sv
verilog/decodeRegister.sv
verilog/fetchDecode.sv
verif/fetchDecode_properties.sv
verif/fetchDecodeTb.sv

// File: verif/fetchTrace.txt
// Program: word count, then the words for byte addresses 0, 2, 4 and so on
// Cycles: count, then redirect target rsData immData stall pc instr regWrite wrAddr memEn err halt valid
001F
0800 4143 DA74 C412 83C1 D000 8962 DB44
950F 6104 4A41 D000 D000 D000 D000 D000
3E04 D000 D000 D000 D000 D000 D000 D000
5725 9A80 88A0 E1B8 3002 0000 4143
0019
// Sequential fetch through ADDI, ADD, LBI, ST and an illegal opcode
0 0000 0000 0000 0 0002 4143 1 2 0 0 0 1
0 0000 0000 0000 0 0004 DA74 1 5 0 0 0 1
0 0000 0000 0000 0 0006 C412 1 4 0 0 0 1
0 0000 0000 0000 0 0008 83C1 0 3 1 0 0 1
0 0000 0000 0000 0 000A D000 0 0 0 1 0 1
// LD r3 then ADD reading r3, one bubble
0 0000 0000 0000 0 000C 8962 1 3 1 0 0 1
0 0000 0000 0000 0 000E 0800 0 0 0 0 0 1
0 0000 0000 0000 0 000E DB44 1 1 0 0 0 1
0 0000 0000 0000 0 0010 950F 1 5 0 0 0 1
0 0000 0000 0000 0 0012 6104 0 1 0 0 0 1
// Redirect to 0x20, then JALR to 0x20 + 0x10
1 0020 0000 0000 0 0014 4A41 1 2 0 0 0 1
0 0000 0020 0010 0 0020 3E04 1 7 0 0 0 1
0 0000 0000 0000 0 0030 5725 1 1 0 0 0 1
// Two stall cycles
0 0000 0000 0000 1 0030 5725 1 1 0 0 0 1
0 0000 0000 0000 1 0030 5725 1 1 0 0 0 1
0 0000 0000 0000 0 0032 9A80 1 2 1 0 0 1
// LD r5, stall on the hazard cycle, then bubble and SEQ
0 0000 0000 0000 0 0034 88A0 1 5 1 0 0 1
0 0000 0000 0000 1 0034 88A0 1 5 1 0 0 1
0 0000 0000 0000 0 0036 0800 0 0 0 0 0 1
0 0000 0000 0000 0 0036 E1B8 1 6 0 0 0 1
0 0000 0000 0000 0 0038 3002 1 7 0 0 0 1
// HALT, later redirect is ignored
0 0000 0000 0000 0 003A 0000 0 0 0 0 1 1
0 0000 0000 0000 0 003A 0000 0 0 0 0 1 1
1 0002 0000 0000 0 003A 0000 0 0 0 0 1 1
0 0000 0000 0000 0 003A 0000 0 0 0 0 1 1
